// File: hw/mem_sequencer.sv
// memory command/response sequencing, address generation, row buffer write strobes
`timescale 1ns/100ps
`include "nice_defs.svh"

module mem_sequencer
   import nice_pkg::*;
(
   input  logic                   custom_mem_op,
   input  logic                   nice_rst_n,
   input  logic                   seq_start,
   input  nice_op_e               cur_op,
   input  logic [`NICE_XLEN-1:0]  base_addr,
   output logic                   nice_icb_cmd_valid,
   input  logic                   nice_icb_cmd_ready,
   output logic [`NICE_XLEN-1:0]  nice_icb_cmd_addr,
   output logic                   nice_icb_cmd_read,
   output logic [`NICE_XLEN-1:0]  nice_icb_cmd_wdata,
   output logic [1:0]             nice_icb_cmd_size,
   input  logic                   nice_icb_rsp_valid,
   output logic                   nice_icb_rsp_ready,
   input  logic [`NICE_XLEN-1:0]  nice_icb_rsp_rdata,
   input  logic                   nice_icb_rsp_err,
   output logic [2:0]             load_we,
   output logic [`NICE_IDX_W-1:0] load_idx,
   output logic [`NICE_XLEN-1:0]  load_data,
   output logic [`NICE_IDX_W-1:0] store_idx,
   input  logic [`NICE_XLEN-1:0]  store_data,
   output logic                   seq_done,
   output logic                   seq_err
);

   // one extra bit so a counter can reach the row depth
   localparam int CNT_W = `NICE_IDX_W + 1;
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`NICE_ROW_DEPTH);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`NICE_ROW_DEPTH - 1);

   logic                  busy;
   logic [CNT_W-1:0]      cmd_cnt;
   logic [CNT_W-1:0]      rsp_cnt;
   logic [`NICE_XLEN-1:0] addr_off;
   logic                  err_q;
   logic                  cmd_hs;
   logic                  rsp_hs;
   logic                  is_load;

   assign cmd_hs  = nice_icb_cmd_valid & nice_icb_cmd_ready;
   assign rsp_hs  = busy & nice_icb_rsp_valid & nice_icb_rsp_ready;
   assign is_load = (cur_op == OP_LOAD_A) | (cur_op == OP_LOAD_B) | (cur_op == OP_LOAD_P);

   //////////////////////////////////////////////////////////////////////
   // command channel
   //////////////////////////////////////////////////////////////////////
   // address and data move only on a command handshake
   assign nice_icb_cmd_valid = busy & (cmd_cnt != CNT_FULL);
   assign nice_icb_cmd_addr  = base_addr + addr_off;
   assign nice_icb_cmd_read  = is_load;
   assign nice_icb_cmd_wdata = is_load ? '0 : store_data;
   assign nice_icb_cmd_size  = `NICE_SIZE_WORD;
   assign store_idx          = cmd_cnt[`NICE_IDX_W-1:0];

   //////////////////////////////////////////////////////////////////////
   // response channel
   //////////////////////////////////////////////////////////////////////
   assign nice_icb_rsp_ready = 1'b1;
   assign load_idx           = rsp_cnt[`NICE_IDX_W-1:0];
   assign load_data          = nice_icb_rsp_rdata;
   assign seq_done           = rsp_hs & (rsp_cnt == CNT_LAST);

   // includes an error on the response in this very cycle
   assign seq_err = err_q | (rsp_hs & nice_icb_rsp_err);

   // steer load responses to the a, b or p row
   always_comb begin
      load_we = 3'b000;
      if (rsp_hs) begin
         case (cur_op)
            OP_LOAD_A: load_we[0] = 1'b1;
            OP_LOAD_B: load_we[1] = 1'b1;
            OP_LOAD_P: load_we[2] = 1'b1;
            default:   load_we = 3'b000;
         endcase
      end
   end

   always_ff @(posedge custom_mem_op) begin
      if (!nice_rst_n) begin
         busy     <= 1'b0;
         cmd_cnt  <= '0;
         rsp_cnt  <= '0;
         addr_off <= '0;
         err_q    <= 1'b0;
      end else if (seq_start) begin
         busy     <= 1'b1;
         cmd_cnt  <= '0;
         rsp_cnt  <= '0;
         addr_off <= '0;
         err_q    <= 1'b0;
      end else if (busy) begin
         if (cmd_hs) begin
            cmd_cnt  <= cmd_cnt + 1'b1;
            addr_off <= addr_off + `NICE_XLEN'(`NICE_WORD_BYTES);
         end
         if (rsp_hs) begin
            rsp_cnt <= rsp_cnt + 1'b1;
            if (nice_icb_rsp_err) err_q <= 1'b1;
         end
         // eighth response ends the operation
         if (seq_done) busy <= 1'b0;
      end
   end

endmodule

// File: hw/modadd_unit.sv
// word-serial modular adder, its result row and the store read port
`timescale 1ns/100ps
`include "nice_defs.svh"

module modadd_unit (
   input  logic                   custom_mem_op,
   input  logic                   nice_rst_n,
   input  logic                   work_start,
   output logic [`NICE_IDX_W-1:0] rd_idx,
   input  logic [`NICE_XLEN-1:0]  a_data,
   input  logic [`NICE_XLEN-1:0]  b_data,
   input  logic [`NICE_XLEN-1:0]  p_data,
   input  logic [`NICE_IDX_W-1:0] store_idx,
   output logic [`NICE_XLEN-1:0]  store_data,
   output logic                   work_done,
   output logic [`NICE_XLEN-1:0]  result_last
);

   localparam int IDX_W = `NICE_IDX_W;
   localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`NICE_ROW_DEPTH - 1);

   logic                  busy;
   logic [IDX_W-1:0]      idx;
   logic [`NICE_XLEN:0]   sum_w;
   logic [`NICE_XLEN:0]   diff_w;
   logic                  ge_p;
   logic [`NICE_XLEN-1:0] mod_w;
   logic [`NICE_XLEN-1:0] res_row [`NICE_ROW_DEPTH];

   //////////////////////////////////////////////////////////////////////
   // one lane per cycle
   //////////////////////////////////////////////////////////////////////
   // 33-bit sum keeps the carry out of the word
   assign sum_w  = {1'b0, a_data} + {1'b0, b_data};
   assign diff_w = sum_w - {1'b0, p_data};
   assign ge_p   = (sum_w >= {1'b0, p_data});

   // a and b below p, so a single subtract is enough
   assign mod_w = ge_p ? diff_w[`NICE_XLEN-1:0] : sum_w[`NICE_XLEN-1:0];

   assign rd_idx      = idx;
   assign work_done   = busy & (idx == IDX_LAST);
   // word in flight, word 7 when work_done is high
   assign result_last = mod_w;

   always_ff @(posedge custom_mem_op) begin
      if (!nice_rst_n) begin
         busy <= 1'b0;
         idx  <= '0;
      end else if (work_start) begin
         busy <= 1'b1;
         idx  <= '0;
      end else if (busy) begin
         idx <= idx + 1'b1;
         if (work_done) busy <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // result row
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge custom_mem_op) begin
      if (busy) begin
         res_row[idx] <= mod_w;
      end
   end

   // read by the sequencer during the store
   assign store_data = res_row[store_idx];

endmodule

// File: hw/nice_core_top.sv
// coprocessor top level: controller, memory sequencer, a/b/p row buffers, modular adder
`timescale 1ns/100ps
`include "nice_defs.svh"

module nice_core_top
   import nice_pkg::*;
(
   input  logic                  custom_mem_op,
   input  logic                  nice_rst_n,
   output logic                  nice_active,
   output logic                  nice_mem_holdup,
   // request channel
   input  logic                  nice_req_valid,
   output logic                  nice_req_ready,
   input  nice_insn_u            nice_req_inst,
   input  logic [`NICE_XLEN-1:0] nice_req_rs1,
   input  logic [`NICE_XLEN-1:0] nice_req_rs2,
   // response channel
   output logic                  nice_rsp_valid,
   input  logic                  nice_rsp_ready,
   output logic [`NICE_XLEN-1:0] nice_rsp_rdat,
   output logic                  nice_rsp_err,
   // memory command
   output logic                  nice_icb_cmd_valid,
   input  logic                  nice_icb_cmd_ready,
   output logic [`NICE_XLEN-1:0] nice_icb_cmd_addr,
   output logic                  nice_icb_cmd_read,
   output logic [`NICE_XLEN-1:0] nice_icb_cmd_wdata,
   output logic [1:0]            nice_icb_cmd_size,
   // memory response
   input  logic                  nice_icb_rsp_valid,
   output logic                  nice_icb_rsp_ready,
   input  logic [`NICE_XLEN-1:0] nice_icb_rsp_rdata,
   input  logic                  nice_icb_rsp_err
);

   nice_op_e                cur_op;
   logic [`NICE_XLEN-1:0]   base_addr;
   logic                    seq_start;
   logic                    seq_done;
   logic                    seq_err;
   logic                    work_start;
   logic                    work_done;
   logic [`NICE_XLEN-1:0]   result_last;
   logic [2:0]              load_we;
   logic [`NICE_IDX_W-1:0]  load_idx;
   logic [`NICE_XLEN-1:0]   load_data;
   logic [`NICE_IDX_W-1:0]  rd_idx;
   logic [`NICE_IDX_W-1:0]  store_idx;
   logic [`NICE_XLEN-1:0]   store_data;
   // 0 is a, 1 is b, 2 is p
   logic [`NICE_XLEN-1:0]   row_rd_data [3];

   // rs2 carries no operand for these instructions
   nice_ctrl u_ctrl (.*);

   mem_sequencer u_seq (.*);

   //////////////////////////////////////////////////////////////////////
   // operand rows
   //////////////////////////////////////////////////////////////////////
   for (genvar g = 0; g < 3; g++) begin : g_row
      row_buffer u_row (
         .custom_mem_op (custom_mem_op),
         .nice_rst_n    (nice_rst_n),
         .wr_en         (load_we[g]),
         .wr_idx        (load_idx),
         .wr_data       (load_data),
         .rd_idx        (rd_idx),
         .rd_data       (row_rd_data[g])
      );
   end

   modadd_unit u_add (
      .*,
      .a_data (row_rd_data[0]),
      .b_data (row_rd_data[1]),
      .p_data (row_rd_data[2])
   );

endmodule

// File: hw/nice_ctrl.sv
// instruction decoder, main FSM, request/response channel and status outputs
`timescale 1ns/100ps
`include "nice_defs.svh"

module nice_ctrl
   import nice_pkg::*;
(
   input  logic                  custom_mem_op,
   input  logic                  nice_rst_n,
   input  logic                  nice_req_valid,
   output logic                  nice_req_ready,
   input  nice_insn_u            nice_req_inst,
   input  logic [`NICE_XLEN-1:0] nice_req_rs1,
   output logic                  nice_rsp_valid,
   input  logic                  nice_rsp_ready,
   output logic [`NICE_XLEN-1:0] nice_rsp_rdat,
   output logic                  nice_rsp_err,
   output logic                  nice_active,
   output logic                  nice_mem_holdup,
   output nice_op_e              cur_op,
   output logic [`NICE_XLEN-1:0] base_addr,
   output logic                  seq_start,
   input  logic                  seq_done,
   input  logic                  seq_err,
   output logic                  work_start,
   input  logic                  work_done,
   input  logic [`NICE_XLEN-1:0] result_last
);

   nice_state_e state;
   nice_op_e    dec_op;
   logic        req_hs;

   //////////////////////////////////////////////////////////////////////
   // decode through the R-type view
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      dec_op = OP_NONE;
      if (nice_req_inst.r.opcode == `NICE_OPCODE_CUSTOM3) begin
         if (nice_req_inst.r.func3 == `NICE_F3_MEM) begin
            case (nice_req_inst.r.func7)
               `NICE_F7_LOAD_A: dec_op = OP_LOAD_A;
               `NICE_F7_LOAD_B: dec_op = OP_LOAD_B;
               `NICE_F7_LOAD_P: dec_op = OP_LOAD_P;
               `NICE_F7_STORE:  dec_op = OP_STORE;
               default:         dec_op = OP_NONE;
            endcase
         end else if (nice_req_inst.r.func3 == `NICE_F3_WORK &&
                      nice_req_inst.r.func7 == `NICE_F7_WORK) begin
            dec_op = OP_WORK;
         end
      end
   end

   assign req_hs = nice_req_valid & nice_req_ready;

   // sequencer and adder start in the acceptance cycle
   assign seq_start  = req_hs & (dec_op != OP_NONE) & (dec_op != OP_WORK);
   assign work_start = req_hs & (dec_op == OP_WORK);

   //////////////////////////////////////////////////////////////////////
   // main FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge custom_mem_op) begin
      if (!nice_rst_n) begin
         state  <= ST_IDLE;
         cur_op <= OP_NONE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (req_hs) begin
                  cur_op <= dec_op;
                  if (dec_op == OP_NONE) begin
                     // illegal, answer at once
                     state <= ST_RESP;
                  end else if (dec_op == OP_WORK) begin
                     state <= ST_WORK;
                  end else begin
                     state <= ST_MEM;
                  end
               end
            end
            ST_MEM:  if (seq_done) state <= ST_RESP;
            ST_WORK: if (work_done) state <= ST_RESP;
            ST_RESP: if (nice_rsp_ready) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // base address and response fields, held until the response handshake
   always_ff @(posedge custom_mem_op) begin
      if (req_hs) begin
         base_addr     <= nice_req_rs1;
         nice_rsp_rdat <= '0;
         nice_rsp_err  <= (dec_op == OP_NONE);
      end
      if (state == ST_MEM && seq_done) begin
         nice_rsp_err <= seq_err;
      end
      if (state == ST_WORK && work_done) begin
         nice_rsp_rdat <= result_last;
      end
   end

   assign nice_req_ready  = (state == ST_IDLE);
   assign nice_rsp_valid  = (state == ST_RESP);
   assign nice_mem_holdup = (state == ST_MEM);
   assign nice_active     = (state != ST_IDLE) | nice_req_valid;

endmodule

// File: hw/nice_defs.svh
// data widths, row geometry, custom3 opcode and function codes, command size code
`ifndef NICE_DEFS_SVH
`define NICE_DEFS_SVH

// data and address width
`define NICE_XLEN           32

// operand and result rows
`define NICE_ROW_DEPTH      8
`define NICE_IDX_W          3
`define NICE_WORD_BYTES     4

// custom3 major opcode, R type only
`define NICE_OPCODE_CUSTOM3 7'b1111011

`define NICE_F3_MEM         3'b010
`define NICE_F3_WORK        3'b000

`define NICE_F7_LOAD_A      7'd1
`define NICE_F7_LOAD_B      7'd2
`define NICE_F7_LOAD_P      7'd3
`define NICE_F7_STORE       7'd4
`define NICE_F7_WORK        7'd5

// size code of a 32-bit memory access
`define NICE_SIZE_WORD      2'b10

`endif

// File: hw/nice_pkg.sv
// R-type field struct, instruction word union, operation and controller state enums
`include "nice_defs.svh"

package nice_pkg;

   // R-type layout, msb first
   typedef struct packed {
      logic [6:0] func7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] func3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } nice_rtype_t;

   // same instruction word, raw or split into fields
   typedef union packed {
      logic [`NICE_XLEN-1:0] raw;
      nice_rtype_t           r;
   } nice_insn_u;

   typedef enum logic [2:0] {
      OP_NONE   = 3'd0,
      OP_LOAD_A = 3'd1,
      OP_LOAD_B = 3'd2,
      OP_LOAD_P = 3'd3,
      OP_STORE  = 3'd4,
      OP_WORK   = 3'd5
   } nice_op_e;

   typedef enum logic [2:0] {
      ST_IDLE = 3'd0,
      ST_MEM  = 3'd1,
      ST_WORK = 3'd2,
      ST_RESP = 3'd3
   } nice_state_e;

endpackage

// File: hw/row_buffer.sv
// eight-word operand row with one indexed write port and one indexed read port
`timescale 1ns/100ps
`include "nice_defs.svh"

module row_buffer (
   input  logic                   custom_mem_op,
   input  logic                   nice_rst_n,
   input  logic                   wr_en,
   input  logic [`NICE_IDX_W-1:0] wr_idx,
   input  logic [`NICE_XLEN-1:0]  wr_data,
   input  logic [`NICE_IDX_W-1:0] rd_idx,
   output logic [`NICE_XLEN-1:0]  rd_data
);

   logic [`NICE_XLEN-1:0] row [`NICE_ROW_DEPTH];

   always_ff @(posedge custom_mem_op) begin
      if (!nice_rst_n) begin
         for (int i = 0; i < `NICE_ROW_DEPTH; i++) begin
            row[i] <= '0;
         end
      end else if (wr_en) begin
         row[wr_idx] <= wr_data;
      end
   end

   // combinational read, a write shows up next cycle
   assign rd_data = row[rd_idx];

endmodule

// File: project.f
+incdir+hw
hw/nice_pkg.sv
hw/nice_ctrl.sv
hw/mem_sequencer.sv
hw/row_buffer.sv
hw/modadd_unit.sv
hw/nice_core_top.sv
testbench/nice_asserts.sv
testbench/tb_nice_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the coprocessor testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing --top-module tb_nice_core \
   -f project.f -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1

grep -qx "NO ERRORS" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: testbench/nice_asserts.sv
// concurrent handshake checks on the response and memory command channels
`timescale 1ns/100ps

module nice_asserts (
   input logic        custom_mem_op,
   input logic        nice_rst_n,
   input logic        nice_req_ready,
   input logic        nice_rsp_valid,
   input logic        nice_rsp_ready,
   input logic [31:0] nice_rsp_rdat,
   input logic        nice_rsp_err,
   input logic        nice_icb_cmd_valid,
   input logic        nice_icb_cmd_ready,
   input logic [31:0] nice_icb_cmd_addr,
   input logic        nice_icb_cmd_read,
   input logic [31:0] nice_icb_cmd_wdata,
   input logic [1:0]  nice_icb_cmd_size
);

   // response held until ready
   rsp_stable: assert property (@(posedge custom_mem_op) disable iff (!nice_rst_n)
      nice_rsp_valid && !nice_rsp_ready |=>
         nice_rsp_valid && $stable(nice_rsp_rdat) && $stable(nice_rsp_err))
      else $error("response changed before ready");

   // command held until ready
   cmd_stable: assert property (@(posedge custom_mem_op) disable iff (!nice_rst_n)
      nice_icb_cmd_valid && !nice_icb_cmd_ready |=>
         nice_icb_cmd_valid && $stable(nice_icb_cmd_addr) && $stable(nice_icb_cmd_read) &&
         $stable(nice_icb_cmd_wdata) && $stable(nice_icb_cmd_size))
      else $error("command changed before ready");

   // idle means ready for a request, never a memory command
   no_idle_cmd: assert property (@(posedge custom_mem_op) disable iff (!nice_rst_n)
      nice_icb_cmd_valid |-> !nice_req_ready)
      else $error("memory command while idle");

endmodule

bind nice_core_top nice_asserts u_asserts (.*);

// File: testbench/tb_nice_core.sv
// testbench top: clock, reset, memory model, stimulus, reference function, comparator, watchdog
`timescale 1ns/100ps
`include "nice_defs.svh"

module tb_nice_core
   import nice_pkg::*;
;

   localparam int NUM_OPS    = 12;
   localparam int OP_CYCLES  = 200;
   localparam int CLK_PERIOD = 10;
   localparam logic [31:0] A_BASE   = 32'h0000_0000;
   localparam logic [31:0] B_BASE   = 32'h0000_0040;
   localparam logic [31:0] P_BASE   = 32'h0000_0080;
   localparam logic [31:0] ERR_BASE = 32'h0000_0300;

   logic        custom_mem_op;
   logic        nice_rst_n;
   logic        nice_active;
   logic        nice_mem_holdup;
   logic        nice_req_valid;
   logic        nice_req_ready;
   nice_insn_u  nice_req_inst;
   logic [31:0] nice_req_rs1;
   logic [31:0] nice_req_rs2;
   logic        nice_rsp_valid;
   logic        nice_rsp_ready;
   logic [31:0] nice_rsp_rdat;
   logic        nice_rsp_err;
   logic        nice_icb_cmd_valid;
   logic        nice_icb_cmd_ready;
   logic [31:0] nice_icb_cmd_addr;
   logic        nice_icb_cmd_read;
   logic [31:0] nice_icb_cmd_wdata;
   logic [1:0]  nice_icb_cmd_size;
   logic        nice_icb_rsp_valid;
   logic        nice_icb_rsp_ready;
   logic [31:0] nice_icb_rsp_rdata;
   logic        nice_icb_rsp_err;

   integer      seed = 73379;
   logic        rand_mode = 1'b0;
   logic [31:0] mem [256];
   logic [31:0] ra [8];
   logic [31:0] rb [8];
   logic [31:0] rp [8];
   // memory model state
   logic [31:0] rsp_data_q [$];
   logic        rsp_err_q [$];
   int          rsp_wait = 0;
   int          cmd_seen = 0;
   logic [31:0] cmd_base = '0;
   logic        cmd_is_read = 1'b0;
   // comparator state
   logic [31:0] exp_rdat_q [$];
   logic        exp_err_q [$];
   logic [31:0] exp_r;
   logic        exp_e;
   int          rsp_seen = 0;

   nice_core_top dut0 (.*);

   always #(CLK_PERIOD / 2) custom_mem_op = ~custom_mem_op;

   task automatic stop_on_error(input string msg);
      $display("** Error at %0t: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped on first error");
   endtask

   // expected lane result as (a + b) mod p
   function automatic logic [31:0] ref_word(input logic [31:0] a, input logic [31:0] b,
                                            input logic [31:0] p);
      logic [63:0] s;
      s = (64'(a) + 64'(b)) % 64'(p);
      return s[31:0];
   endfunction

   function automatic nice_insn_u make_insn(input logic [6:0] f7, input logic [2:0] f3);
      nice_insn_u u;
      u.raw      = '0;
      u.r.opcode = `NICE_OPCODE_CUSTOM3;
      u.r.func3  = f3;
      u.r.func7  = f7;
      u.r.rs1    = 5'd10;
      return u;
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // memory model
   ///////////////////////////////////////////////////////////////////////
   always @(posedge custom_mem_op) begin
      if (!nice_rst_n) begin
         rsp_data_q.delete();
         rsp_err_q.delete();
         rsp_wait = 0;
         nice_icb_rsp_valid <= 1'b0;
         nice_icb_cmd_ready <= 1'b0;
         nice_rsp_ready     <= 1'b1;
      end else begin
         if (nice_icb_rsp_valid && nice_icb_rsp_ready) begin
            rsp_data_q.delete(0);
            rsp_err_q.delete(0);
            rsp_wait = $unsigned($random(seed)) % 3;
         end else if (rsp_wait > 0) begin
            rsp_wait--;
         end
         if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
            assert (nice_icb_cmd_addr == cmd_base + 32'(cmd_seen * 4))
               else stop_on_error($sformatf("command address %h", nice_icb_cmd_addr));
            assert (nice_icb_cmd_read == cmd_is_read && nice_icb_cmd_size == `NICE_SIZE_WORD)
               else stop_on_error("wrong command direction or size");
            assert (nice_mem_holdup && nice_active)
               else stop_on_error("memory holdup or active low during a command");
            cmd_seen++;
            if (nice_icb_cmd_read) begin
               rsp_data_q.push_back(mem[nice_icb_cmd_addr[9:2]]);
            end else begin
               mem[nice_icb_cmd_addr[9:2]] = nice_icb_cmd_wdata;
               rsp_data_q.push_back('0);
            end
            // error window of eight words
            rsp_err_q.push_back(nice_icb_cmd_addr[31:5] == ERR_BASE[31:5]);
         end
         nice_icb_cmd_ready <= rand_mode ? $random(seed) % 2 != 0 : 1'b1;
         nice_rsp_ready     <= rand_mode ? $random(seed) % 2 != 0 : 1'b1;
         if (rsp_data_q.size() > 0 && rsp_wait == 0) begin
            nice_icb_rsp_valid <= 1'b1;
            nice_icb_rsp_rdata <= rsp_data_q[0];
            nice_icb_rsp_err   <= rsp_err_q[0];
         end else begin
            nice_icb_rsp_valid <= 1'b0;
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // response comparator
   ///////////////////////////////////////////////////////////////////////
   always @(posedge custom_mem_op) begin
      if (nice_rst_n && nice_rsp_valid && nice_rsp_ready) begin
         assert (exp_rdat_q.size() > 0)
            else stop_on_error("response without an outstanding request");
         exp_r = exp_rdat_q.pop_front();
         exp_e = exp_err_q.pop_front();
         assert (nice_rsp_rdat == exp_r)
            else stop_on_error($sformatf("rdat %h, expected %h", nice_rsp_rdat, exp_r));
         assert (nice_rsp_err == exp_e)
            else stop_on_error($sformatf("err %b, expected %b", nice_rsp_err, exp_e));
         rsp_seen++;
      end
   end

   // issue one instruction and wait for its response
   task automatic run_op(input nice_insn_u insn, input logic [31:0] rs1,
                         input logic [31:0] exp_rdat, input logic exp_err,
                         input int exp_cmds, input logic exp_read);
      int start;
      start = rsp_seen;
      exp_rdat_q.push_back(exp_rdat);
      exp_err_q.push_back(exp_err);
      cmd_base    = rs1;
      cmd_is_read = exp_read;
      cmd_seen    = 0;
      nice_req_valid <= 1'b1;
      nice_req_inst  <= insn;
      nice_req_rs1   <= rs1;
      @(posedge custom_mem_op);
      while (!nice_req_ready) @(posedge custom_mem_op);
      assert (nice_active)
         else stop_on_error("active low while a request waits");
      nice_req_valid <= 1'b0;
      while (rsp_seen == start) @(posedge custom_mem_op);
      @(posedge custom_mem_op);
      assert (rsp_seen == start + 1)
         else stop_on_error("response count off after one request");
      assert (cmd_seen == exp_cmds)
         else stop_on_error($sformatf("%0d memory commands, expected %0d", cmd_seen, exp_cmds));
   endtask

   // load random rows, add them, store and check memory
   task automatic add_round(input logic [31:0] store_base);
      for (int i = 0; i < 8; i++) begin
         rp[i] = $random(seed);
         if (rp[i] < 32'd2) rp[i] = 32'd2;
         ra[i] = $unsigned($random(seed)) % rp[i];
         rb[i] = $unsigned($random(seed)) % rp[i];
         mem[A_BASE[9:2] + 8'(i)] = ra[i];
         mem[B_BASE[9:2] + 8'(i)] = rb[i];
         mem[P_BASE[9:2] + 8'(i)] = rp[i];
      end
      run_op(make_insn(`NICE_F7_LOAD_A, `NICE_F3_MEM), A_BASE, '0, 1'b0, 8, 1'b1);
      run_op(make_insn(`NICE_F7_LOAD_B, `NICE_F3_MEM), B_BASE, '0, 1'b0, 8, 1'b1);
      run_op(make_insn(`NICE_F7_LOAD_P, `NICE_F3_MEM), P_BASE, '0, 1'b0, 8, 1'b1);
      run_op(make_insn(`NICE_F7_WORK, `NICE_F3_WORK), '0,
             ref_word(ra[7], rb[7], rp[7]), 1'b0, 0, 1'b0);
      run_op(make_insn(`NICE_F7_STORE, `NICE_F3_MEM), store_base, '0, 1'b0, 8, 1'b0);
      for (int i = 0; i < 8; i++) begin
         assert (mem[store_base[9:2] + 8'(i)] == ref_word(ra[i], rb[i], rp[i]))
            else stop_on_error($sformatf("stored word %0d is %h", i,
                                         mem[store_base[9:2] + 8'(i)]));
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // stimulus
   ///////////////////////////////////////////////////////////////////////
   initial begin
      custom_mem_op  = 1'b0;
      nice_rst_n     = 1'b0;
      nice_req_valid = 1'b0;
      nice_req_inst  = '0;
      nice_req_rs1   = '0;
      nice_req_rs2   = '0;
      nice_rsp_ready     = 1'b1;
      nice_icb_cmd_ready = 1'b0;
      nice_icb_rsp_valid = 1'b0;
      nice_icb_rsp_rdata = '0;
      nice_icb_rsp_err   = 1'b0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
      end
      repeat (10) @(posedge custom_mem_op);
      nice_rst_n <= 1'b1;
      @(posedge custom_mem_op);
      assert (!nice_rsp_valid && !nice_icb_cmd_valid && !nice_active && !nice_mem_holdup)
         else stop_on_error("status or valid outputs high after reset");
      // illegal func7 under the memory func3
      run_op(make_insn(7'd9, `NICE_F3_MEM), 32'h40, '0, 1'b1, 0, 1'b0);
      run_op(make_insn(`NICE_F7_LOAD_A, `NICE_F3_MEM), ERR_BASE, '0, 1'b1, 8, 1'b1);
      add_round(32'h0000_0100);
      rand_mode = 1'b1;
      add_round(32'h0000_0180);
      repeat (4) @(posedge custom_mem_op);
      if (rsp_seen == NUM_OPS) begin
         $display("NO ERRORS");
      end else begin
         stop_on_error($sformatf("%0d responses seen, expected %0d", rsp_seen, NUM_OPS));
      end
      $finish;
   end

   // watchdog
   initial begin
      #((10 + NUM_OPS * OP_CYCLES) * CLK_PERIOD);
      $display("watchdog timeout: the tests did not finish in time");
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

endmodule
